/* all.f */
+incdir+.
axi_wr_pkg.sv
axi_burst_write_master.sv
axi_write_mem_slave.sv
axi_write_subsystem.sv
tb_axi_write_subsystem.sv

/* Bender.yml */
package:
  name: axi_write_subsystem

export_include_dirs:
  - .

sources:
  # Design, package first
  - include_dirs:
      - .
    files:
      - axi_wr_pkg.sv
      - axi_burst_write_master.sv
      - axi_write_mem_slave.sv
      - axi_write_subsystem.sv

  # Simulation only
  - target: test
    include_dirs:
      - .
    files:
      - tb_axi_write_subsystem.sv

/* tb_axi_write_subsystem.sv */
// Memory has no reset, so the first burst sweeps all of it before any readback compare is valid
`timescale 1ns/10ps
`include "axi_wr_settings.svh"

module tb_axi_write_subsystem
	import axi_wr_pkg::*;
();

	localparam int MEM_WORDS      = `AXW_MEM_WORDS;
	localparam int MAX_BURSTS     = 16;                // Bursts issued below, rounded up
	localparam int BURST_CYCLES   = 4 * MEM_WORDS + 20; // Longest burst with stalls
	localparam int SWEEP_CYCLES   = MEM_WORDS + 2;     // One full readback
	localparam int TIMEOUT_CYCLES = MAX_BURSTS * (BURST_CYCLES + SWEEP_CYCLES) + 100;

	logic                       clk;
	logic                       resetn;
	logic                       start_write;
	logic [`AXW_ADDR_WIDTH-1:0] write_addr;
	logic [`AXW_LEN_WIDTH-1:0]  write_len;
	logic [2:0]                 write_size;
	burst_t                     write_burst;
	logic [`AXW_DATA_WIDTH-1:0] write_data;
	logic                       w_hold;
	logic [`AXW_ADDR_WIDTH-1:0] rd_addr;
	logic                       beat_take;
	logic                       done;
	logic                       busy;
	logic                       wr_error;
	logic [`AXW_DATA_WIDTH-1:0] rd_data;

	logic [31:0]                lfsr = 32'h2f8a;      // Galois state
	logic [`AXW_DATA_WIDTH-1:0] shadow [0:MEM_WORDS-1]; // Expected memory contents
	logic [`AXW_DATA_WIDTH-1:0] word_q [$];            // Current burst, head is on the bus
	int                         take_cnt;              // beat_take pulses this burst
	int                         cyc;
	int                         err_data;
	int                         err_ctrl;
	int                         err_done;
	bit                         cmp_req;               // Readback sweep requested

	axi_write_subsystem u_axi_write_subsystem (
		.clk, .resetn, .start_write, .write_addr, .write_len, .write_size, .write_burst,
		.write_data, .w_hold, .rd_addr, .beat_take, .done, .busy, .wr_error, .rd_data
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	// One LFSR step per returned bit, taps for x^32+x^22+x^2+x+1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        b;
		r = '0;
		for (int i = 0; i < n; i++) begin
			b    = lfsr[0];
			lfsr = lfsr >> 1;
			if (b)
				lfsr = lfsr ^ 32'h8020_0003;
			r = {r[30:0], b};
		end
		return r;
	endfunction

	// Apply a burst to the shadow memory, returns the expected error flag
	function automatic logic ref_burst(input logic [`AXW_ADDR_WIDTH-1:0] addr,
		input logic [`AXW_LEN_WIDTH-1:0] len, input burst_t burst);
		int last;
		int a;
		if (burst != FIXED && burst != INCR)
			return 1'b1; // WRAP and reserved rejected
		last = int'(addr) + ((burst == INCR) ? int'(len) : 0);
		if (last >= MEM_WORDS)
			return 1'b1; // Some beat falls off the end
		for (int i = 0; i <= int'(len); i++) begin
			a = (burst == INCR) ? int'(addr) + i : int'(addr);
			shadow[a] = word_q[i]; // FIXED keeps only the last word
		end
		return 1'b0;
	endfunction

	// Data supplier, steps to the next word after each accepted beat
	initial begin
		forever begin
			@(posedge clk);
			if (beat_take) begin
				take_cnt++;
				#1;
				if (word_q.size() > 0)
					void'(word_q.pop_front());
				write_data = (word_q.size() > 0) ? word_q[0] : '0;
			end
		end
	end

	// Readback compare against the shadow memory
	initial begin
		forever begin
			wait (cmp_req);
			for (int a = 0; a < MEM_WORDS; a++) begin
				rd_addr = a;
				@(posedge clk);
				#1; // rd_data registered on that edge
				if (rd_data !== shadow[a]) begin
					$display("** Error at %0t: mem[%0d] reads %h, expected %h",
						$time, a, rd_data, shadow[a]);
					err_data++;
				end
			end
			cmp_req = 1'b0;
		end
	end

	// Watchdog
	initial begin
		cyc = 0;
		while (cyc <= TIMEOUT_CYCLES) begin
			@(posedge clk);
			cyc++;
		end
		$display("Run stopped after %0d cycles because the test sequence never finished", cyc);
		$display("tests failed");
		$finish;
	end

	task automatic check_memory();
		cmp_req = 1'b1;
		wait (!cmp_req);
	endtask

	task automatic check_idle();
		if (beat_take !== 1'b0 || done !== 1'b0 || busy !== 1'b0 || wr_error !== 1'b0) begin
			$display("** Error at %0t: outputs not low after reset", $time);
			err_ctrl++;
		end
	endtask

	// One burst from strobe to done, called just after an edge
	task automatic run_burst(input logic [`AXW_ADDR_WIDTH-1:0] addr,
		input logic [`AXW_LEN_WIDTH-1:0] len, input burst_t burst, input bit stall, input bit stray);
		int   n;
		int   k;
		int   limit;
		logic exp_err;
		bit   got_done;
		n     = int'(len) + 1;
		limit = 4 * n + 20;
		word_q.delete();
		for (int i = 0; i < n; i++)
			word_q.push_back(rand_bits(`AXW_DATA_WIDTH));
		exp_err     = ref_burst(addr, len, burst);
		take_cnt    = 0;
		write_data  = word_q[0];
		write_addr  = addr;
		write_len   = len;
		write_size  = 3'd2; // Full word
		write_burst = burst;
		start_write = 1'b1;
		@(posedge clk); // Strobe taken here
		#1;
		start_write = 1'b0;
		k           = 0;
		got_done    = 1'b0;
		while (!got_done && k < limit) begin
			@(posedge clk);
			k++;
			if (done)
				got_done = 1'b1;
			if (busy !== 1'b1) begin
				$display("** Error at %0t: busy low %0d cycles into a burst", $time, k);
				err_ctrl++;
			end
			#1;
			start_write = stray && (k == 1); // Extra strobe while busy
			if (stray && k == 1) begin
				write_addr = 16'd200;
				write_len  = 8'd3;
			end
			w_hold = stall ? (rand_bits(2) == 2'b11) : 1'b0; // About one cycle in four
		end
		w_hold = 1'b0;
		if (!got_done) begin
			$display("Burst at address %0d never signalled done within %0d cycles", addr, limit);
			err_done++;
		end else if (!stall && k + 1 != n + 3) begin
			// Strobe cycle through done cycle inclusive
			$display("** Error at %0t: burst of %0d beats took %0d cycles, expected %0d",
				$time, n, k + 1, n + 3);
			err_ctrl++;
		end
		if (wr_error !== exp_err) begin
			$display("** Error at %0t: wr_error %b, expected %b", $time, wr_error, exp_err);
			err_ctrl++;
		end
		if (take_cnt != n) begin
			$display("** Error at %0t: %0d beat_take pulses, expected %0d", $time, take_cnt, n);
			err_ctrl++;
		end
	endtask

	initial begin
		logic [`AXW_ADDR_WIDTH-1:0] a;
		logic [`AXW_LEN_WIDTH-1:0]  l;
		resetn      = 1'b0;
		start_write = 1'b0;
		write_addr  = '0;
		write_len   = '0;
		write_size  = 3'd2;
		write_burst = INCR;
		write_data  = '0;
		w_hold      = 1'b0;
		rd_addr     = '0;
		repeat (3) @(posedge clk);
		#1;
		resetn = 1'b1;
		check_idle();

		run_burst(16'd0, 8'd255, INCR, 1'b0, 1'b0); // Sweep fills every word
		check_memory();
		repeat (2) begin
			a = rand_bits(7);
			l = rand_bits(6); // Stays inside the memory
			run_burst(a, l, INCR, 1'b0, 1'b0);
			check_memory();
		end

		// FIXED, only the last word survives
		repeat (2) begin
			a = 16'd40 + rand_bits(4);
			l = 8'd1 + rand_bits(3);
			run_burst(a, l, FIXED, 1'b0, 1'b0);
			check_memory();
		end

		// Random back-pressure
		repeat (4) begin
			a = rand_bits(7);
			l = rand_bits(6);
			run_burst(a, l, INCR, 1'b1, 1'b0);
			check_memory();
		end

		// Rejected requests leave memory alone
		a = 16'd240 + rand_bits(4);
		l = 8'd16 + rand_bits(3); // Runs past the top
		run_burst(a, l, INCR, 1'b0, 1'b0);
		check_memory();
		a = rand_bits(7);
		run_burst(a, 8'd3, WRAP, 1'b0, 1'b0);
		check_memory();

		// Back to back, each with an ignored strobe mid burst
		repeat (3) begin
			a = rand_bits(7);
			l = rand_bits(5);
			run_burst(a, l, INCR, 1'b0, 1'b1);
		end
		check_memory();

		$display("Error counts: data %0d, control %0d, missing done %0d",
			err_data, err_ctrl, err_done);
		if (err_data + err_ctrl + err_done == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* axi_write_subsystem.sv */
// Master and slave joined directly; w_hold and the read port are for test access only
`timescale 1ns/10ps
`include "axi_wr_settings.svh"

module axi_write_subsystem
	import axi_wr_pkg::*;
(
	input  logic                       clk,
	input  logic                       resetn,
	input  logic                       start_write,
	input  logic [`AXW_ADDR_WIDTH-1:0] write_addr,
	input  logic [`AXW_LEN_WIDTH-1:0]  write_len,
	input  logic [2:0]                 write_size,
	input  burst_t                     write_burst,
	input  logic [`AXW_DATA_WIDTH-1:0] write_data,
	input  logic                       w_hold,
	input  logic [`AXW_ADDR_WIDTH-1:0] rd_addr,
	output logic                       beat_take,
	output logic                       done,
	output logic                       busy,
	output logic                       wr_error,
	output logic [`AXW_DATA_WIDTH-1:0] rd_data
);

	// AXI wires between the two
	logic [`AXW_ADDR_WIDTH-1:0] awaddr;
	logic [`AXW_LEN_WIDTH-1:0]  awlen;
	logic [2:0]                 awsize;
	burst_t                     awburst;
	logic                       awvalid, awready;
	logic [`AXW_DATA_WIDTH-1:0] wdata;
	logic                       wlast, wvalid, wready;
	logic                       bvalid, bready;
	resp_t                      bresp;

	axi_burst_write_master u_master (
		.clk, .resetn,
		.start_write, .write_addr, .write_len, .write_size, .write_burst, .write_data,
		.awaddr, .awlen, .awsize, .awburst, .awvalid, .awready,
		.wdata, .wlast, .wvalid, .wready,
		.bvalid, .bresp, .bready,
		.beat_take, .done, .busy, .wr_error
	);

	axi_write_mem_slave u_slave (
		.clk, .resetn,
		.awaddr, .awlen, .awsize, .awburst, .awvalid, .awready,
		.wdata, .wlast, .wvalid, .wready,
		.bvalid, .bresp, .bready,
		.w_hold, .rd_addr, .rd_data
	);

endmodule

/* axi_write_mem_slave.sv */
// FIXED and INCR only, no strobes or IDs; rd_addr aliases above the memory depth
`timescale 1ns/10ps
`include "axi_wr_settings.svh"

module axi_write_mem_slave
	import axi_wr_pkg::*;
(
	input  logic                       clk,
	input  logic                       resetn,

	// AW channel
	input  logic [`AXW_ADDR_WIDTH-1:0] awaddr,
	input  logic [`AXW_LEN_WIDTH-1:0]  awlen,
	input  logic [2:0]                 awsize,
	input  burst_t                     awburst,
	input  logic                       awvalid,
	output logic                       awready,

	// W channel
	input  logic [`AXW_DATA_WIDTH-1:0] wdata,
	input  logic                       wlast,
	input  logic                       wvalid,
	output logic                       wready,

	// B channel
	output logic                       bvalid,
	output resp_t                      bresp,
	input  logic                       bready,

	// Test hooks
	input  logic                       w_hold,  // Stalls wready while high
	input  logic [`AXW_ADDR_WIDTH-1:0] rd_addr,
	output logic [`AXW_DATA_WIDTH-1:0] rd_data  // One cycle latency
);

	localparam int MEM_AW = $clog2(`AXW_MEM_WORDS);
	localparam logic [`AXW_ADDR_WIDTH:0] MEM_LIMIT = `AXW_MEM_WORDS;

	logic [`AXW_DATA_WIDTH-1:0] mem [0:`AXW_MEM_WORDS-1];

	logic                       in_data;  // Data phase active
	logic                       bvalid_q;
	logic                       err_q;    // Request rejected
	logic [`AXW_ADDR_WIDTH-1:0] cur_addr; // Address of the next beat
	logic [`AXW_LEN_WIDTH-1:0]  len_q;
	burst_t                     burst_q;
	logic [`AXW_LEN_WIDTH-1:0]  beat_cnt;
	logic                       last_beat;
	logic                       aw_hs;
	logic                       w_hs;
	logic [`AXW_ADDR_WIDTH:0]   end_addr; // Extra bit so a wrap past the top is caught
	logic                       bad_burst;
	logic                       bad_range;

	assign awready = !in_data && !bvalid_q; // Idle means ready
	assign wready  = in_data && !w_hold;
	assign aw_hs   = awvalid && awready;
	assign w_hs    = wvalid && wready;

	// Check the request on AW
	assign bad_burst = (awburst != FIXED) && (awburst != INCR);
	always_comb begin
		if (awburst == INCR)
			end_addr = {1'b0, awaddr} + (`AXW_ADDR_WIDTH+1)'(awlen); // Last beat address
		else
			end_addr = {1'b0, awaddr}; // FIXED never moves
	end
	assign bad_range = (end_addr >= MEM_LIMIT);

	// Own count of the burst, independent of wlast
	assign last_beat = (beat_cnt == len_q);

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			in_data  <= 1'b0;
			bvalid_q <= 1'b0;
			err_q    <= 1'b0;
			beat_cnt <= '0;
		end else begin
			if (aw_hs) begin
				in_data  <= 1'b1;
				beat_cnt <= '0;
				err_q    <= bad_burst || bad_range;
			end else if (w_hs) begin
				beat_cnt <= beat_cnt + 1'b1; // Holds while stalled
				if (last_beat) begin
					in_data  <= 1'b0;
					bvalid_q <= 1'b1; // Response on the next cycle
				end
			end
			if (bvalid_q && bready)
				bvalid_q <= 1'b0;
		end
	end

	// Burst payload
	always_ff @(posedge clk) begin
		if (aw_hs) begin
			cur_addr <= awaddr;
			len_q    <= awlen;
			burst_q  <= awburst;
		end else if (w_hs && burst_q == INCR) begin
			cur_addr <= cur_addr + 1'b1; // One word per beat
		end
	end

	// Write only accepted requests, range already proven at AW
	always_ff @(posedge clk) begin
		if (w_hs && !err_q)
			mem[cur_addr[MEM_AW-1:0]] <= wdata;
	end

	// Registered read port
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr[MEM_AW-1:0]];
	end

	assign bvalid = bvalid_q;
	assign bresp  = err_q ? SLVERR : OKAY;

	// Master's wlast must agree with our own beat count
	a_wlast_match: assert property (@(posedge clk) disable iff (!resetn)
		w_hs |-> (wlast == last_beat))
		else $error("wlast does not match the counted last beat");

	// Response withdrawn only once it was taken
	a_bvalid_hold: assert property (@(posedge clk) disable iff (!resetn)
		$fell(bvalid) |-> $past(bready))
		else $error("bvalid dropped before bready");

	// A beat never claims more bytes than the data bus carries
	a_awsize_fit: assert property (@(posedge clk) disable iff (!resetn)
		awvalid |-> ((8 << awsize) <= `AXW_DATA_WIDTH))
		else $error("awsize wider than the data bus");

endmodule

/* axi_burst_write_master.sv */
// One burst at a time; write_data must show the current beat whenever wvalid is high
`timescale 1ns/10ps
`include "axi_wr_settings.svh"

module axi_burst_write_master
	import axi_wr_pkg::*;
(
	input  logic                       clk,
	input  logic                       resetn,

	// Control side
	input  logic                       start_write,
	input  logic [`AXW_ADDR_WIDTH-1:0] write_addr,
	input  logic [`AXW_LEN_WIDTH-1:0]  write_len,
	input  logic [2:0]                 write_size,
	input  burst_t                     write_burst,
	input  logic [`AXW_DATA_WIDTH-1:0] write_data,

	// AW channel
	output logic [`AXW_ADDR_WIDTH-1:0] awaddr,
	output logic [`AXW_LEN_WIDTH-1:0]  awlen,
	output logic [2:0]                 awsize,
	output burst_t                     awburst,
	output logic                       awvalid,
	input  logic                       awready,

	// W channel
	output logic [`AXW_DATA_WIDTH-1:0] wdata,
	output logic                       wlast,
	output logic                       wvalid,
	input  logic                       wready,

	// B channel
	input  logic                       bvalid,
	input  resp_t                      bresp,
	output logic                       bready,

	// Status back to the supplier
	output logic                       beat_take,
	output logic                       done,
	output logic                       busy,
	output logic                       wr_error
);

	wr_state_t                  state, state_nxt;
	logic [`AXW_ADDR_WIDTH-1:0] addr_q;   // Latched request
	logic [`AXW_LEN_WIDTH-1:0]  len_q;
	logic [2:0]                 size_q;
	burst_t                     burst_q;
	logic [`AXW_LEN_WIDTH-1:0]  beat_cnt; // Beats accepted so far
	logic                       err_q;
	logic                       start_ok;
	logic                       aw_hs;
	logic                       w_hs;
	logic                       b_hs;

	assign start_ok = start_write && (state == WR_IDLE); // Strobe ignored while busy
	assign aw_hs    = awvalid && awready;
	assign w_hs     = wvalid && wready;
	assign b_hs     = bvalid && bready;

	// Phase sequencing
	always_comb begin
		state_nxt = state;
		case (state)
			WR_IDLE: if (start_ok)          state_nxt = WR_ADDR;
			WR_ADDR: if (aw_hs)             state_nxt = WR_DATA;
			WR_DATA: if (w_hs && wlast)     state_nxt = WR_RESP;
			WR_RESP: if (b_hs)              state_nxt = WR_IDLE;
			default:                        state_nxt = WR_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state    <= WR_IDLE;
			beat_cnt <= '0;
			err_q    <= 1'b0;
		end else begin
			state <= state_nxt;
			if (start_ok) begin
				beat_cnt <= '0;   // Fresh count per burst
				err_q    <= 1'b0; // Status clears on a new start
			end else if (w_hs) begin
				beat_cnt <= beat_cnt + 1'b1; // Holds on stall cycles
			end
			if (b_hs)
				err_q <= (bresp == SLVERR);
		end
	end

	// Request fields, stable for the whole burst
	always_ff @(posedge clk) begin
		if (start_ok) begin
			addr_q  <= write_addr;
			len_q   <= write_len;
			size_q  <= write_size;
			burst_q <= write_burst;
		end
	end

	// AW channel straight from the latch
	assign awaddr  = addr_q;
	assign awlen   = len_q;
	assign awsize  = size_q;   // Carried only
	assign awburst = burst_q;
	assign awvalid = (state == WR_ADDR);

	// W channel
	assign wdata  = write_data;          // Supplier holds it until beat_take
	assign wvalid = (state == WR_DATA);
	assign wlast  = (beat_cnt == len_q); // Final beat of len_q + 1

	assign bready = (state == WR_RESP);

	assign beat_take = w_hs;       // Supplier steps to the next word
	assign done      = b_hs;
	assign busy      = (state != WR_IDLE);
	assign wr_error  = err_q;

	// A presented beat stays up until the slave takes it
	a_wvalid_hold: assert property (@(posedge clk) disable iff (!resetn)
		wvalid && !wready |=> wvalid)
		else $error("wvalid dropped without a handshake");

	// AW only right after an accepted start or while still unanswered
	a_awvalid_phase: assert property (@(posedge clk) disable iff (!resetn)
		awvalid |-> $past(start_ok) || ($past(awvalid) && !$past(awready)))
		else $error("awvalid outside the address phase");

endmodule

/* axi_wr_pkg.sv */
// Shared AXI write types; only FIXED and INCR bursts are served, WRAP is rejected by the slave
package axi_wr_pkg;

	// AXI burst encodings
	typedef enum logic [1:0] {
		FIXED = 2'b00, // Same address every beat
		INCR  = 2'b01, // Address steps by one word
		WRAP  = 2'b10  // Not supported here
	} burst_t;

	// Write response codes in use
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} resp_t;

	// Master phase sequence
	typedef enum logic [1:0] {
		WR_IDLE, // Waiting for start_write
		WR_ADDR, // AW presented
		WR_DATA, // Streaming beats
		WR_RESP  // Waiting for B
	} wr_state_t;

endpackage

/* axi_wr_settings.svh */
// Word addressed widths; changing AXW_MEM_WORDS needs a power of two for the memory index
`ifndef AXI_WR_SETTINGS_SVH
`define AXI_WR_SETTINGS_SVH

// Address bits on AW and on the read port
`define AXW_ADDR_WIDTH 16

// One data word per beat
`define AXW_DATA_WIDTH 32

// AXI length field, beats = len + 1
`define AXW_LEN_WIDTH 8

// Memory depth in words
// Addresses at or above this are out of range
`define AXW_MEM_WORDS 256

`endif
